// File: hdl/perf_consts.svh
`ifndef PERF_CONSTS_SVH
`define PERF_CONSTS_SVH

// bus widths
`define PERF_DATA_W        32
`define PERF_ADDR_W        8

// ways on the channel, the map has room for 15
`define PERF_WAY           4

// fields of the packed count word
`define PERF_PROG_CNT_W    10
`define PERF_READ_CNT_W    12
`define PERF_ERASE_CNT_W   10

// global registers
`define PERF_REG_CONFIG    8'h00
`define PERF_REG_STATUS    8'h04

// way w block base is (w+1)*stride
`define PERF_WAY_STRIDE    8'h10
`define PERF_OFS_PROG      8'h00
`define PERF_OFS_READ      8'h04
`define PERF_OFS_ERASE     8'h08
`define PERF_OFS_COUNTS    8'h0C

`endif

// File: hdl/perf_pkg.sv
`include "perf_consts.svh"

package perf_pkg;

  typedef logic [`PERF_DATA_W-1:0] data_t;
  typedef logic [`PERF_ADDR_W-1:0] addr_t;
  typedef logic [31:0]             cycles_t;

  typedef enum logic {
    OP_IDLE,
    OP_BUSY
  } op_state_t;

  typedef struct packed {
    addr_t paddr;
    logic  psel;
    logic  penable;
    logic  pwrite;
    data_t pwdata;
  } apb_req_t;

  // single-cycle pulses from the channel controller
  typedef struct packed {
    logic prog_start;
    logic prog_end;
    logic read_start;
    logic read_end;
    logic erase_start;
    logic erase_end;
    logic op_fail;
  } flash_evt_t;

  // one status nibble
  typedef struct packed {
    logic prog_ready;
    logic read_ready;
    logic erase_ready;
    logic fail;
  } way_status_t;

  typedef struct packed {
    logic prog;
    logic read;
    logic erase;
    logic fail;
  } way_clear_t;

  typedef struct packed {
    cycles_t prog_cycles;
    cycles_t read_cycles;
    cycles_t erase_cycles;
    data_t   counts;       // prog, read, erase from msb
  } way_counts_t;

  // config bits 2:0
  typedef struct packed {
    logic erase;
    logic read;
    logic prog;
  } op_enable_t;

endpackage

// File: hdl/perf_op_counter.sv
`timescale 1ns/1ps

module perf_op_counter #(
  parameter int COUNT_W = 10
) (
  input  logic               i_bus_clk,
  input  logic               i_bus_rstn,
  input  logic               i_enable,
  input  logic               i_start,
  input  logic               i_end,
  input  logic               i_fail,
  input  logic               i_clear,
  output perf_pkg::cycles_t  o_cycles,
  output logic [COUNT_W-1:0] o_count,
  output logic               o_ready
);

  localparam int CYC_W = $bits(perf_pkg::cycles_t);

  perf_pkg::op_state_t r_state;
  perf_pkg::cycles_t   r_run;      // edges of this op before its end edge
  perf_pkg::cycles_t   r_cycles;
  logic [COUNT_W-1:0]  r_count;
  logic                r_ready;
  perf_pkg::cycles_t   w_run_total;
  logic [CYC_W:0]      w_sum;
  perf_pkg::cycles_t   w_cycles_next;
  logic                w_done_ok;

  // the end edge itself also counts
  assign w_run_total = (r_run == '1) ? r_run : r_run + 1'b1;
  assign w_sum = {1'b0, r_cycles} + {1'b0, w_run_total};
  assign w_cycles_next = w_sum[CYC_W] ? '1 : w_sum[CYC_W-1:0];
  assign w_done_ok = (r_state == perf_pkg::OP_BUSY) && i_end && !i_fail;

  always_ff @(posedge i_bus_clk or negedge i_bus_rstn)
  begin
    if (!i_bus_rstn)
    begin
      r_state <= perf_pkg::OP_IDLE;
      r_run   <= '0;
    end
    else
    begin
      case (r_state)
        perf_pkg::OP_IDLE:
        begin
          if (i_start && i_enable)
          begin
            r_state <= perf_pkg::OP_BUSY;
            r_run   <= '0;
          end
        end
        perf_pkg::OP_BUSY:
        begin
          if (i_end)
            r_state <= perf_pkg::OP_IDLE; // this op is over either way
          else
            r_run <= w_run_total;
        end
      endcase
    end
  end

  // a read clear beats a same-cycle end
  always_ff @(posedge i_bus_clk or negedge i_bus_rstn)
  begin
    if (!i_bus_rstn)
    begin
      r_cycles <= '0;
      r_count  <= '0;
      r_ready  <= 1'b0;
    end
    else if (i_clear)
    begin
      r_cycles <= '0;
      r_count  <= '0;
      r_ready  <= 1'b0;
    end
    else if (w_done_ok)
    begin
      r_cycles <= w_cycles_next;
      if (r_count != '1)
        r_count <= r_count + 1'b1;
      r_ready <= 1'b1;
    end
  end

  assign o_cycles = r_cycles;
  assign o_count  = r_count;
  assign o_ready  = r_ready;

  a_cycles_no_drop: assert property (@(posedge i_bus_clk) disable iff (!i_bus_rstn)
    !$past(i_clear) |-> (r_cycles >= $past(r_cycles)));

  // every committed op adds at least one cycle
  a_cycles_cover_count: assert property (@(posedge i_bus_clk) disable iff (!i_bus_rstn)
    r_cycles >= perf_pkg::cycles_t'(r_count));

endmodule

// File: hdl/perf_way_monitor.sv
`timescale 1ns/1ps
`include "perf_consts.svh"

module perf_way_monitor (
  input  logic                  i_bus_clk,
  input  logic                  i_bus_rstn,
  input  perf_pkg::op_enable_t  i_enable,
  input  perf_pkg::flash_evt_t  i_evt,
  input  perf_pkg::way_clear_t  i_clear,
  output perf_pkg::way_status_t o_status,
  output perf_pkg::way_counts_t o_counts
);

  logic                         w_prog_fail;
  logic                         w_read_fail;
  logic                         w_erase_fail;
  logic                         r_fail;
  perf_pkg::cycles_t            w_prog_cycles;
  perf_pkg::cycles_t            w_read_cycles;
  perf_pkg::cycles_t            w_erase_cycles;
  logic [`PERF_PROG_CNT_W-1:0]  w_prog_cnt;
  logic [`PERF_READ_CNT_W-1:0]  w_read_cnt;
  logic [`PERF_ERASE_CNT_W-1:0] w_erase_cnt;
  logic                         w_prog_ready;
  logic                         w_read_ready;
  logic                         w_erase_ready;

  // op_fail only belongs to the kind ending this cycle
  assign w_prog_fail  = i_evt.op_fail & i_evt.prog_end;
  assign w_read_fail  = i_evt.op_fail & i_evt.read_end;
  assign w_erase_fail = i_evt.op_fail & i_evt.erase_end;

  perf_op_counter #(.COUNT_W(`PERF_PROG_CNT_W)) u_prog (
    .i_bus_clk  (i_bus_clk),
    .i_bus_rstn (i_bus_rstn),
    .i_enable   (i_enable.prog),
    .i_start    (i_evt.prog_start),
    .i_end      (i_evt.prog_end),
    .i_fail     (w_prog_fail),
    .i_clear    (i_clear.prog),
    .o_cycles   (w_prog_cycles),
    .o_count    (w_prog_cnt),
    .o_ready    (w_prog_ready)
  );

  perf_op_counter #(.COUNT_W(`PERF_READ_CNT_W)) u_read (
    .i_bus_clk  (i_bus_clk),
    .i_bus_rstn (i_bus_rstn),
    .i_enable   (i_enable.read),
    .i_start    (i_evt.read_start),
    .i_end      (i_evt.read_end),
    .i_fail     (w_read_fail),
    .i_clear    (i_clear.read),
    .o_cycles   (w_read_cycles),
    .o_count    (w_read_cnt),
    .o_ready    (w_read_ready)
  );

  perf_op_counter #(.COUNT_W(`PERF_ERASE_CNT_W)) u_erase (
    .i_bus_clk  (i_bus_clk),
    .i_bus_rstn (i_bus_rstn),
    .i_enable   (i_enable.erase),
    .i_start    (i_evt.erase_start),
    .i_end      (i_evt.erase_end),
    .i_fail     (w_erase_fail),
    .i_clear    (i_clear.erase),
    .o_cycles   (w_erase_cycles),
    .o_count    (w_erase_cnt),
    .o_ready    (w_erase_ready)
  );

  // sticky until status is read
  always_ff @(posedge i_bus_clk or negedge i_bus_rstn)
  begin
    if (!i_bus_rstn)
      r_fail <= 1'b0;
    else if (i_clear.fail)
      r_fail <= 1'b0;
    else if (w_prog_fail || w_read_fail || w_erase_fail)
      r_fail <= 1'b1;
  end

  assign o_status = '{prog_ready: w_prog_ready, read_ready: w_read_ready,
                      erase_ready: w_erase_ready, fail: r_fail};

  assign o_counts = '{prog_cycles: w_prog_cycles, read_cycles: w_read_cycles,
                      erase_cycles: w_erase_cycles,
                      counts: {w_prog_cnt, w_read_cnt, w_erase_cnt}};

endmodule

// File: hdl/perf_apb_regs.sv
`timescale 1ns/1ps
`include "perf_consts.svh"

module perf_apb_regs (
  input  logic                                   i_bus_clk,
  input  logic                                   i_bus_rstn,
  input  perf_pkg::apb_req_t                     i_apb,
  output perf_pkg::data_t                        o_prdata,
  output logic                                   o_pready,
  output logic                                   o_pslverr,
  output perf_pkg::op_enable_t                   o_enable,
  input  perf_pkg::way_status_t [`PERF_WAY-1:0]  i_status,
  input  perf_pkg::way_counts_t [`PERF_WAY-1:0]  i_counts,
  output perf_pkg::way_clear_t  [`PERF_WAY-1:0]  o_clear
);

  perf_pkg::op_enable_t r_config;
  perf_pkg::addr_t      w_blk;
  perf_pkg::addr_t      w_ofs;
  perf_pkg::data_t      w_status_word;
  perf_pkg::data_t      w_data;
  logic                 w_access;
  logic                 w_rd;
  logic                 w_sel_cfg;
  logic                 w_sel_stat;
  logic [`PERF_WAY-1:0] w_sel_prog;
  logic [`PERF_WAY-1:0] w_sel_read;
  logic [`PERF_WAY-1:0] w_sel_erase;
  logic [`PERF_WAY-1:0] w_sel_cnt;
  logic                 w_hit;
  logic                 w_err;

  assign w_access = i_apb.psel & i_apb.penable;
  assign w_rd     = w_access & ~i_apb.pwrite;

  // split the address into way block and offset
  assign w_ofs = i_apb.paddr & perf_pkg::addr_t'(`PERF_WAY_STRIDE - 1);
  assign w_blk = i_apb.paddr & ~perf_pkg::addr_t'(`PERF_WAY_STRIDE - 1);

  assign w_sel_cfg  = (i_apb.paddr == `PERF_REG_CONFIG);
  assign w_sel_stat = (i_apb.paddr == `PERF_REG_STATUS);

  always_comb
  begin
    w_sel_prog  = '0;
    w_sel_read  = '0;
    w_sel_erase = '0;
    w_sel_cnt   = '0;
    for (int w = 0; w < `PERF_WAY; w++)
    begin
      if (w_blk == perf_pkg::addr_t'((w + 1) * `PERF_WAY_STRIDE))
      begin
        w_sel_prog[w]  = (w_ofs == `PERF_OFS_PROG);
        w_sel_read[w]  = (w_ofs == `PERF_OFS_READ);
        w_sel_erase[w] = (w_ofs == `PERF_OFS_ERASE);
        w_sel_cnt[w]   = (w_ofs == `PERF_OFS_COUNTS);
      end
    end
  end

  assign w_hit = w_sel_cfg | w_sel_stat | (|w_sel_prog) | (|w_sel_read) |
                 (|w_sel_erase) | (|w_sel_cnt);

  // only config takes writes
  assign w_err = ~w_hit | (i_apb.pwrite & ~w_sel_cfg);

  // nibble per way, way 0 lowest; ways past 7 fall off the word
  assign w_status_word = perf_pkg::data_t'(i_status);

  always_comb
  begin
    w_data = '0;
    if (w_sel_cfg)
      w_data = perf_pkg::data_t'(r_config);
    if (w_sel_stat)
      w_data = w_status_word;
    for (int w = 0; w < `PERF_WAY; w++)
    begin
      if (w_sel_prog[w])
        w_data = i_counts[w].prog_cycles;
      if (w_sel_read[w])
        w_data = i_counts[w].read_cycles;
      if (w_sel_erase[w])
        w_data = i_counts[w].erase_cycles;
      if (w_sel_cnt[w])
        w_data = i_counts[w].counts;
    end
  end

  always_ff @(posedge i_bus_clk or negedge i_bus_rstn)
  begin
    if (!i_bus_rstn)
      r_config <= '0;
    else if (w_access && i_apb.pwrite && w_sel_cfg)
      r_config <= perf_pkg::op_enable_t'(i_apb.pwdata[2:0]);
  end

  // read side effects land at the edge closing the access
  always_comb
  begin
    for (int w = 0; w < `PERF_WAY; w++)
    begin
      o_clear[w].prog  = w_rd & w_sel_prog[w];
      o_clear[w].read  = w_rd & w_sel_read[w];
      o_clear[w].erase = w_rd & w_sel_erase[w];
      o_clear[w].fail  = w_rd & w_sel_stat;
    end
  end

  assign o_prdata  = (w_rd && !w_err) ? w_data : '0;
  assign o_pready  = 1'b1;  // no wait states
  assign o_pslverr = w_access & w_err;
  assign o_enable  = r_config;

  // an error only shows in an access phase that follows its setup phase
  a_err_in_access: assert property (@(posedge i_bus_clk) disable iff (!i_bus_rstn)
    o_pslverr |-> i_apb.penable && $past(i_apb.psel && !i_apb.penable));

endmodule

// File: hdl/perf_monitor_top.sv
`timescale 1ns/1ps
`include "perf_consts.svh"

module perf_monitor_top (
  input  logic                                  i_bus_clk,
  input  logic                                  i_bus_rstn,
  input  perf_pkg::apb_req_t                    i_apb,
  output perf_pkg::data_t                       o_prdata,
  output logic                                  o_pready,
  output logic                                  o_pslverr,
  input  perf_pkg::flash_evt_t [`PERF_WAY-1:0]  i_way_evt
);

  perf_pkg::op_enable_t                  w_enable;
  perf_pkg::way_status_t [`PERF_WAY-1:0] w_status;
  perf_pkg::way_counts_t [`PERF_WAY-1:0] w_counts;
  perf_pkg::way_clear_t  [`PERF_WAY-1:0] w_clear;

  perf_apb_regs u_regs (
    .i_bus_clk  (i_bus_clk),
    .i_bus_rstn (i_bus_rstn),
    .i_apb      (i_apb),
    .o_prdata   (o_prdata),
    .o_pready   (o_pready),
    .o_pslverr  (o_pslverr),
    .o_enable   (w_enable),
    .i_status   (w_status),
    .i_counts   (w_counts),
    .o_clear    (w_clear)
  );

  // one monitor per way, all sharing the config enables
  for (genvar w = 0; w < `PERF_WAY; w++)
  begin : g_way
    perf_way_monitor u_way (
      .i_bus_clk  (i_bus_clk),
      .i_bus_rstn (i_bus_rstn),
      .i_enable   (w_enable),
      .i_evt      (i_way_evt[w]),
      .i_clear    (w_clear[w]),
      .o_status   (w_status[w]),
      .o_counts   (w_counts[w])
    );
  end

endmodule

// File: bench/tb_perf_tasks.svh
// setup then access phase, outputs sampled mid access phase
task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                        output logic [31:0] rdata, output logic err);
  @(negedge bus_clk);
  apb_req = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: wr, pwdata: wdata};
  @(negedge bus_clk);
  apb_req.penable = 1'b1;
  #1;
  rdata = prdata;
  err = pslverr;
  check_value("pready", 32'd1, {31'b0, pready});
  @(negedge bus_clk);
  apb_req = '0;
endtask

task automatic reg_expect(input logic [7:0] addr, input logic [31:0] exp, input string what);
  logic [31:0] d;
  logic        e;
  apb_xfer(1'b0, addr, '0, d, e);
  check_value(what, exp, d);
  check_value({what, " pslverr"}, 32'd0, {31'b0, e});
endtask

task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
  logic [31:0] d;
  logic        e;
  apb_xfer(1'b1, addr, data, d, e);
  check_value("write pslverr", 32'd0, {31'b0, e});
endtask

function automatic logic [7:0] way_addr(input int w, input logic [7:0] ofs);
  return 8'((w + 1) * `PERF_WAY_STRIDE) + ofs;
endfunction

function automatic logic [31:0] count_word(input int p, input int r, input int e);
  return {`PERF_PROG_CNT_W'(p), `PERF_READ_CNT_W'(r), `PERF_ERASE_CNT_W'(e)};
endfunction

task automatic add_op(input int w, input int k, input int start, input int len, input logic fl);
  op_start[w][k] = start;
  op_len[w][k]   = len;
  op_fail[w][k]  = fl;
endtask

// 41 cycles covers a start up to 7 plus a length up to 32, last cycle idle
task automatic play_ops();
  logic [2:0] st;
  logic [2:0] en;
  logic       fl;
  for (int t = 0; t <= 40; t++)
  begin
    @(negedge bus_clk);
    for (int w = 0; w < `PERF_WAY; w++)
    begin
      st = '0;
      en = '0;
      fl = 1'b0;
      for (int k = 0; k < 3; k++)
      begin
        if (op_len[w][k] != 0)
        begin
          st[k] = (t == op_start[w][k]);
          en[k] = (t == op_start[w][k] + op_len[w][k]);
          fl = fl | (en[k] & op_fail[w][k]);
        end
      end
      way_evt[w] = '{prog_start: st[0], prog_end: en[0], read_start: st[1],
                     read_end: en[1], erase_start: st[2], erase_end: en[2], op_fail: fl};
    end
  end
  op_len = '{default: 0};
endtask

task automatic test_reset();
  begin_test("reset");
  reg_expect(`PERF_REG_CONFIG, 32'd0, "config");
  reg_expect(`PERF_REG_STATUS, 32'd0, "status");
  for (int w = 0; w < `PERF_WAY; w++)
    for (int o = 0; o < 16; o += 4)
      reg_expect(way_addr(w, 8'(o)), 32'd0, "way register");
  end_test();
endtask

task automatic test_config();
  logic [31:0] d;
  logic        e;
  begin_test("config");
  reg_write(`PERF_REG_CONFIG, 32'd7);
  reg_expect(`PERF_REG_CONFIG, 32'd7, "config readback");
  apb_xfer(1'b0, 8'hF0, '0, d, e);
  check_value("unmapped read data", 32'd0, d);
  check_value("unmapped read pslverr", 32'd1, {31'b0, e});
  apb_xfer(1'b1, way_addr(0, `PERF_OFS_PROG), 32'hFFFF_FFFF, d, e);
  check_value("bad write data", 32'd0, d);
  check_value("bad write pslverr", 32'd1, {31'b0, e});
  reg_expect(`PERF_REG_CONFIG, 32'd7, "config after bad write");
  end_test();
endtask

task automatic test_counting();
  int n1;
  int n2;
  begin_test("counting");
  reg_write(`PERF_REG_CONFIG, 32'd1); // prog only
  n1 = rand_len();
  n2 = rand_len();
  add_op(0, 0, 0, n1, 1'b0);
  play_ops();
  add_op(0, 0, 0, n2, 1'b0);
  play_ops();
  reg_expect(`PERF_REG_STATUS, 32'h8, "status prog_ready");
  reg_expect(way_addr(0, `PERF_OFS_COUNTS), count_word(2, 0, 0), "count word");
  reg_expect(way_addr(0, `PERF_OFS_PROG), 32'(n1 + n2), "prog cycles");
  reg_expect(way_addr(0, `PERF_OFS_PROG), 32'd0, "prog cycles after clear");
  reg_expect(way_addr(0, `PERF_OFS_COUNTS), 32'd0, "count word after clear");
  reg_expect(`PERF_REG_STATUS, 32'd0, "status after clear");
  end_test();
endtask

task automatic test_disable();
  int n;
  begin_test("disable");
  reg_write(`PERF_REG_CONFIG, 32'd5); // read kind off
  n = rand_len();
  add_op(1, 1, 0, rand_len(), 1'b0);
  add_op(1, 2, 2, n, 1'b0);
  play_ops();
  reg_expect(`PERF_REG_STATUS, 32'h20, "status"); // way 1 erase_ready only
  reg_expect(way_addr(1, `PERF_OFS_COUNTS), count_word(0, 0, 1), "count word");
  reg_expect(way_addr(1, `PERF_OFS_READ), 32'd0, "read cycles");
  reg_expect(way_addr(1, `PERF_OFS_ERASE), 32'(n), "erase cycles");
  end_test();
endtask

task automatic test_fail();
  begin_test("fail");
  add_op(2, 2, 0, rand_len(), 1'b1);
  play_ops();
  reg_expect(`PERF_REG_STATUS, 32'h100, "status fail bit");
  reg_expect(`PERF_REG_STATUS, 32'd0, "status after read");
  reg_expect(way_addr(2, `PERF_OFS_COUNTS), 32'd0, "count word");
  reg_expect(way_addr(2, `PERF_OFS_ERASE), 32'd0, "erase cycles");
  end_test();
endtask

task automatic test_concurrency();
  int len [`PERF_WAY][3];
  int first;
  int w;
  begin_test("concurrency");
  reg_write(`PERF_REG_CONFIG, 32'd7);
  for (int i = 0; i < `PERF_WAY; i++)
    for (int k = 0; k < 3; k++)
    begin
      len[i][k] = rand_len();
      add_op(i, k, int'(rand_bits(3)), len[i][k], 1'b0);
    end
  play_ops();
  reg_expect(`PERF_REG_STATUS, 32'({`PERF_WAY{4'hE}}), "status all ready");
  first = int'(rand_bits(4)) % `PERF_WAY; // random way goes first
  for (int i = 0; i < `PERF_WAY; i++)
  begin
    w = (first + i) % `PERF_WAY;
    reg_expect(way_addr(w, `PERF_OFS_COUNTS), count_word(1, 1, 1), "count word");
    reg_expect(way_addr(w, `PERF_OFS_PROG), 32'(len[w][0]), "prog cycles");
    reg_expect(way_addr(w, `PERF_OFS_READ), 32'(len[w][1]), "read cycles");
    reg_expect(way_addr(w, `PERF_OFS_ERASE), 32'(len[w][2]), "erase cycles");
  end
  reg_expect(`PERF_REG_STATUS, 32'd0, "status after clears");
  end_test();
endtask

// File: bench/tb_perf_monitor.sv
`timescale 1ns/1ps
`include "perf_consts.svh"

module tb_perf_monitor;

  localparam int TIMEOUT_CYCLES = 4000; // tests take a few hundred cycles

  logic                                 bus_clk = 1'b0;
  logic                                 bus_rstn;
  perf_pkg::apb_req_t                   apb_req;
  perf_pkg::data_t                      prdata;
  logic                                 pready;
  logic                                 pslverr;
  perf_pkg::flash_evt_t [`PERF_WAY-1:0] way_evt;

  logic [31:0] lfsr = 32'h2218_788e;
  int          n_checks = 0;
  int          n_errors = 0;
  int          test_first_err = 0;
  string       test_name = "";
  int          cycle_cnt = 0;

  // flash op schedule per way and kind (prog, read, erase), len 0 is unused
  int          op_start [`PERF_WAY][3];
  int          op_len   [`PERF_WAY][3];
  logic        op_fail  [`PERF_WAY][3];

  always #2 bus_clk = ~bus_clk;

  perf_monitor_top DUT (
    .i_bus_clk  (bus_clk),
    .i_bus_rstn (bus_rstn),
    .i_apb      (apb_req),
    .o_prdata   (prdata),
    .o_pready   (pready),
    .o_pslverr  (pslverr),
    .i_way_evt  (way_evt)
  );

  // galois lfsr, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic int rand_len();
    return int'(rand_bits(5)) + 1; // 1 to 32 cycles
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    n_checks++;
    if (expected !== actual)
    begin
      n_errors++;
      $display("Mismatch in %s (%s): expected 0x%08h, actual 0x%08h",
               test_name, what, expected, actual);
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_first_err = n_errors;
  endtask

  task automatic end_test();
    $display("test %s finished, %0d mismatches", test_name, n_errors - test_first_err);
  endtask

  `include "tb_perf_tasks.svh"

  always @(posedge bus_clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES)
    begin
      $display("timeout: tests did not finish");
      $display("** FAIL **");
      $finish;
    end
  end

  initial
  begin
    apb_req  = '0;
    way_evt  = '0;
    bus_rstn = 1'b0;
    op_len   = '{default: 0};
    op_start = '{default: 0};
    op_fail  = '{default: 1'b0};
    repeat (8) @(posedge bus_clk);
    @(negedge bus_clk);
    bus_rstn = 1'b1;

    test_reset();
    test_config();
    test_counting();
    test_disable();
    test_fail();
    test_concurrency();

    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// File: sources.f
+incdir+hdl
+incdir+bench
hdl/perf_pkg.sv
hdl/perf_op_counter.sv
hdl/perf_way_monitor.sv
hdl/perf_apb_regs.sv
hdl/perf_monitor_top.sv
bench/tb_perf_monitor.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module tb_perf_monitor \
	  --Mdir obj_dir -o tb_perf_monitor
	@out="$$(./obj_dir/tb_perf_monitor)"; echo "$$out"; \
	  echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf obj_dir
